// ==== logic/mem_pkg.sv ====
package mem_pkg;

	// byte address into the 1 MiB memory
	localparam int ADDR_W = 20;

	// one storage line and the word carried by the core and APB write paths
	localparam int LINE_W = 128;
	localparam int WORD_W = 32;

	// lines are addressed by bits 19 to 4 of the byte address
	localparam int INDEX_W = 16;

	// bytes per line, one write enable each
	localparam int LANES = LINE_W / 8;

	typedef logic [ADDR_W-1:0] addr_t;

	typedef logic [INDEX_W-1:0] index_t;

	typedef logic [LINE_W-1:0] line_t;

	typedef logic [WORD_W-1:0] word_t;

	// bit n enables byte n of a line, byte 0 being bits 7 to 0
	typedef logic [LANES-1:0] byte_en_t;

endpackage

// ==== logic/line_bus_if.sv ====
`timescale 1ns/1ps

interface line_bus_if
	import mem_pkg::*;
();

	// read request and the line it returns one cycle later
	logic rd_req;
	addr_t rd_addr;
	logic rd_ready;
	line_t rd_data;
	addr_t rd_addr_echo;

	// word or byte write, applied at the edge it is sampled
	logic wr_en;
	logic wr_byte;
	addr_t wr_addr;
	word_t wr_data;

	modport requester (
		output rd_req, rd_addr, wr_en, wr_byte, wr_addr, wr_data,
		input rd_ready, rd_data, rd_addr_echo
	);

	modport memory (
		input rd_req, rd_addr, wr_en, wr_byte, wr_addr, wr_data,
		output rd_ready, rd_data, rd_addr_echo
	);

endinterface

// ==== logic/line_store.sv ====
`timescale 1ns/1ps

module line_store
	import mem_pkg::*;
(
	input logic clk,

	input logic st_rd_en_i,
	input index_t st_rd_index_i,
	output line_t st_rd_line_o,

	input logic st_wr_en_i,
	input index_t st_wr_index_i,
	input byte_en_t st_wr_be_i,
	input line_t st_wr_line_i
);

	line_t mem_q [0:(2**INDEX_W)-1];

	// the read register holds its line until the next read, and
	// sees the array from before a write at the same edge
	always_ff @(posedge clk) begin
		if (st_rd_en_i) begin
			st_rd_line_o <= mem_q[st_rd_index_i];
		end
	end

	// only the enabled bytes of the addressed line change
	always_ff @(posedge clk) begin
		if (st_wr_en_i) begin
			for (int b = 0; b < LANES; b++) begin
				if (st_wr_be_i[b]) begin
					mem_q[st_wr_index_i][b*8 +: 8] <= st_wr_line_i[b*8 +: 8];
				end
			end
		end
	end

endmodule

// ==== logic/lane_merge.sv ====
`timescale 1ns/1ps

module lane_merge
	import mem_pkg::*;
(
	input logic mg_valid_i,
	input logic mg_byte_i,
	input addr_t mg_addr_i,
	input word_t mg_data_i,

	output logic st_wr_en_o,
	output index_t st_wr_index_o,
	output byte_en_t st_wr_be_o,
	output line_t st_wr_line_o
);

	assign st_wr_en_o = mg_valid_i;
	assign st_wr_index_o = mg_addr_i[ADDR_W-1 -: INDEX_W];

	// data is copied into every lane, the mask picks which lanes land
	always_comb begin
		if (mg_byte_i) begin
			st_wr_be_o = byte_en_t'(1) << mg_addr_i[3:0];
			st_wr_line_o = {LANES{mg_data_i[7:0]}};
		end else begin
			st_wr_be_o = byte_en_t'(4'hf) << {mg_addr_i[3:2], 2'b00};
			st_wr_line_o = {(LINE_W / WORD_W){mg_data_i}};
		end
	end

endmodule

// ==== logic/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl
	import mem_pkg::*;
(
	input logic clk,
	input logic arst_n_i,

	line_bus_if.memory bus,

	input logic host_req_i,
	input logic host_we_i,
	input addr_t host_addr_i,
	input word_t host_wdata_i,
	output logic host_grant_o,
	output word_t host_rdata_o,

	output logic st_rd_en_o,
	output index_t st_rd_index_o,
	input line_t st_rd_line_i,

	output logic mg_valid_o,
	output logic mg_byte_o,
	output addr_t mg_addr_o,
	output word_t mg_data_o
);

	logic core_busy;
	logic host_rd;
	addr_t rd_addr_sel;

	// record of the read that the store is answering in this cycle
	logic rec_core_rd_q;
	logic rec_host_rd_q;
	addr_t rec_addr_q;

	// any core access owns the store, the host only gets an empty cycle
	assign core_busy = bus.rd_req | bus.wr_en;
	assign host_grant_o = host_req_i & ~core_busy;
	assign host_rd = host_grant_o & ~host_we_i;

	assign rd_addr_sel = bus.rd_req ? bus.rd_addr : host_addr_i;

	assign st_rd_en_o = bus.rd_req | host_rd;
	assign st_rd_index_o = rd_addr_sel[ADDR_W-1 -: INDEX_W];

	// core writes go straight to the merge, host writes only once granted
	assign mg_valid_o = bus.wr_en | (host_grant_o & host_we_i);
	assign mg_byte_o = bus.wr_en ? bus.wr_byte : 1'b0;
	assign mg_addr_o = bus.wr_en ? bus.wr_addr : host_addr_i;
	assign mg_data_o = bus.wr_en ? bus.wr_data : host_wdata_i;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rec_core_rd_q <= 1'b0;
			rec_host_rd_q <= 1'b0;
		end else begin
			rec_core_rd_q <= bus.rd_req;
			rec_host_rd_q <= host_rd;
		end
	end

	always_ff @(posedge clk) begin
		if (st_rd_en_o) begin
			rec_addr_q <= rd_addr_sel;
		end
	end

	assign bus.rd_ready = rec_core_rd_q;
	assign bus.rd_data = st_rd_line_i;
	assign bus.rd_addr_echo = rec_addr_q;

	// the host reads one word, picked from the line by address bits 3 to 2
	assign host_rdata_o = rec_host_rd_q ? st_rd_line_i[rec_addr_q[3:2]*WORD_W +: WORD_W] : '0;

	// the APB port drops its request in the cycle after a grant,
	// so each host transfer uses the store only once
	a_grant_once: assert property (@(posedge clk) disable iff (!arst_n_i)
		host_grant_o |=> !host_req_i)
	else $error("host request still high after its grant");

endmodule

// ==== logic/apb_host_port.sv ====
`timescale 1ns/1ps

module apb_host_port
	import mem_pkg::*;
(
	input logic clk,
	input logic arst_n_i,

	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input addr_t paddr_i,
	input word_t pwdata_i,
	output word_t prdata_o,
	output logic pready_o,
	output logic pslverr_o,

	output logic host_req_o,
	output logic host_we_o,
	output addr_t host_addr_o,
	output word_t host_wdata_o,
	input logic host_grant_i,
	input word_t host_rdata_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCESS,
		S_RESPOND
	} state_t;

	state_t state_q;
	state_t state_d;
	logic aligned;
	logic access;

	assign aligned = (paddr_i[1:0] == 2'b00);
	assign access = (state_q == S_ACCESS) & psel_i & penable_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			S_IDLE: begin
				if (psel_i) begin
					state_d = S_ACCESS;
				end
			end
			S_ACCESS: begin
				// an unaligned transfer is finished by the error response
				if (!psel_i) begin
					state_d = S_IDLE;
				end else if (penable_i) begin
					if (!aligned) begin
						state_d = S_IDLE;
					end else if (host_grant_i) begin
						state_d = S_RESPOND;
					end
				end
			end
			S_RESPOND: begin
				state_d = S_IDLE;
			end
			default: begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// the request holds for the whole access phase until the grant
	assign host_req_o = access & aligned;
	assign host_we_o = pwrite_i;
	assign host_addr_o = paddr_i;
	assign host_wdata_o = pwdata_i;

	assign pslverr_o = access & ~aligned;
	assign pready_o = (state_q == S_RESPOND) | pslverr_o;

	// read data arrives from the store in the cycle after the grant
	assign prdata_o = (state_q == S_RESPOND) ? host_rdata_i : '0;

	// the master must hold address and direction until the transfer ends
	a_apb_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		(psel_i && !pready_o) |=> ($stable(paddr_i) && $stable(pwrite_i)))
	else $error("APB address or direction changed during a transfer");

endmodule

// ==== logic/line_mem_top.sv ====
`timescale 1ns/1ps

module line_mem_top
	import mem_pkg::*;
(
	input logic clk,
	input logic arst_n_i,

	input logic mem_read_i,
	input addr_t mem_read_addr_i,
	input logic mem_write_enable_i,
	input logic mem_write_byte_i,
	input addr_t mem_write_addr_i,
	input word_t mem_write_data_i,
	output logic mem_data_ready_o,
	output line_t mem_data_o,
	output addr_t mem_addr_o,

	input logic psel_i,
	input logic penable_i,
	input logic pwrite_i,
	input addr_t paddr_i,
	input word_t pwdata_i,
	output word_t prdata_o,
	output logic pready_o,
	output logic pslverr_o
);

	logic host_req;
	logic host_we;
	addr_t host_addr;
	word_t host_wdata;
	logic host_grant;
	word_t host_rdata;

	logic st_rd_en;
	index_t st_rd_index;
	line_t st_rd_line;

	logic mg_valid;
	logic mg_byte;
	addr_t mg_addr;
	word_t mg_data;

	logic st_wr_en;
	index_t st_wr_index;
	byte_en_t st_wr_be;
	line_t st_wr_line;

	line_bus_if bus ();

	// the core side pins map one to one onto the bundle
	assign bus.rd_req = mem_read_i;
	assign bus.rd_addr = mem_read_addr_i;
	assign bus.wr_en = mem_write_enable_i;
	assign bus.wr_byte = mem_write_byte_i;
	assign bus.wr_addr = mem_write_addr_i;
	assign bus.wr_data = mem_write_data_i;

	assign mem_data_ready_o = bus.rd_ready;
	assign mem_data_o = bus.rd_data;
	assign mem_addr_o = bus.rd_addr_echo;

	apb_host_port u_apb (
		.clk (clk),
		.arst_n_i (arst_n_i),
		.psel_i (psel_i),
		.penable_i (penable_i),
		.pwrite_i (pwrite_i),
		.paddr_i (paddr_i),
		.pwdata_i (pwdata_i),
		.prdata_o (prdata_o),
		.pready_o (pready_o),
		.pslverr_o (pslverr_o),
		.host_req_o (host_req),
		.host_we_o (host_we),
		.host_addr_o (host_addr),
		.host_wdata_o (host_wdata),
		.host_grant_i (host_grant),
		.host_rdata_i (host_rdata)
	);

	mem_ctrl u_ctrl (
		.clk (clk),
		.arst_n_i (arst_n_i),
		.bus (bus),
		.host_req_i (host_req),
		.host_we_i (host_we),
		.host_addr_i (host_addr),
		.host_wdata_i (host_wdata),
		.host_grant_o (host_grant),
		.host_rdata_o (host_rdata),
		.st_rd_en_o (st_rd_en),
		.st_rd_index_o (st_rd_index),
		.st_rd_line_i (st_rd_line),
		.mg_valid_o (mg_valid),
		.mg_byte_o (mg_byte),
		.mg_addr_o (mg_addr),
		.mg_data_o (mg_data)
	);

	lane_merge u_merge (
		.mg_valid_i (mg_valid),
		.mg_byte_i (mg_byte),
		.mg_addr_i (mg_addr),
		.mg_data_i (mg_data),
		.st_wr_en_o (st_wr_en),
		.st_wr_index_o (st_wr_index),
		.st_wr_be_o (st_wr_be),
		.st_wr_line_o (st_wr_line)
	);

	line_store u_store (
		.clk (clk),
		.st_rd_en_i (st_rd_en),
		.st_rd_index_i (st_rd_index),
		.st_rd_line_o (st_rd_line),
		.st_wr_en_i (st_wr_en),
		.st_wr_index_i (st_wr_index),
		.st_wr_be_i (st_wr_be),
		.st_wr_line_i (st_wr_line)
	);

endmodule

// ==== testbench/tb_line_mem.sv ====
`timescale 1ns/1ps

module tb_line_mem
	import mem_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int READ_TIMEOUT = 8;
	localparam int APB_TIMEOUT = 60;

	logic clk;
	logic arst_n_i;
	logic mem_read_i;
	addr_t mem_read_addr_i;
	logic mem_write_enable_i;
	logic mem_write_byte_i;
	addr_t mem_write_addr_i;
	word_t mem_write_data_i;
	logic mem_data_ready_o;
	line_t mem_data_o;
	addr_t mem_addr_o;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	addr_t paddr_i;
	word_t pwdata_i;
	word_t prdata_o;
	logic pready_o;
	logic pslverr_o;

	// expected memory contents, keyed by line index
	line_t shadow [index_t];
	integer seed;
	int errors;
	int checks;
	int tests;

	line_mem_top UUT (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic index_t line_of(input addr_t a);
		return a[ADDR_W-1:4];
	endfunction

	function automatic word_t word_of(input line_t l, input addr_t a);
		return l[a[3:2]*WORD_W +: WORD_W];
	endfunction

	task automatic check(input string name, input line_t exp, input line_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	// a byte lands at bits 3 to 0 of the address, a word at bits 3 to 2
	task automatic apply_write(input logic byte_wr, input addr_t a, input word_t d);
		line_t l;
		l = shadow[line_of(a)];
		if (byte_wr) begin
			l[a[3:0]*8 +: 8] = d[7:0];
		end else begin
			l[a[3:2]*WORD_W +: WORD_W] = d;
		end
		shadow[line_of(a)] = l;
	endtask

	task automatic pick_line(output addr_t a);
		logic [31:0] rnd;
		rnd = $random(seed);
		a = {rnd[19:4], 4'h0};
	endtask

	task automatic drive_write(input logic byte_wr, input addr_t a, input word_t d);
		mem_write_enable_i = 1'b1;
		mem_write_byte_i = byte_wr;
		mem_write_addr_i = a;
		mem_write_data_i = d;
	endtask

	// all core and APB tasks start and end on a falling edge
	task automatic core_write(input logic byte_wr, input addr_t a, input word_t d);
		drive_write(byte_wr, a, d);
		@(negedge clk);
		mem_write_enable_i = 1'b0;
		apply_write(byte_wr, a, d);
	endtask

	task automatic fill_line(input addr_t base);
		for (int w = 0; w < 4; w++) begin
			core_write(1'b0, base + addr_t'(w * 4), $random(seed));
		end
	endtask

	task automatic read_line(input string name, input addr_t a, input line_t exp);
		int n;
		mem_read_i = 1'b1;
		mem_read_addr_i = a;
		@(negedge clk);
		mem_read_i = 1'b0;
		mem_write_enable_i = 1'b0;
		n = 1;
		while (!mem_data_ready_o && n < READ_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!mem_data_ready_o) begin
			errors++;
			$display("%s: no read response for address %h within %0d cycles", name, a, n);
		end else begin
			check({name, " latency"}, line_t'(1), line_t'(n));
			check({name, " data"}, exp, mem_data_o);
			check({name, " echo"}, line_t'(a), line_t'(mem_addr_o));
			@(negedge clk);
			check({name, " ready pulse"}, line_t'(0), line_t'(mem_data_ready_o));
		end
	endtask

	// waits counts the access cycles that passed before PREADY
	task automatic apb_xfer(input string name, input logic wr, input addr_t a, input word_t wd,
		output word_t rd, output logic err, output int waits);
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		rd = '0;
		err = 1'b0;
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = wr;
		paddr_i = a;
		pwdata_i = wd;
		@(negedge clk);
		penable_i = 1'b1;
		while (!done && n < APB_TIMEOUT) begin
			#(CLK_PERIOD / 4);
			if (pready_o) begin
				done = 1'b1;
				rd = prdata_o;
				err = pslverr_o;
			end else begin
				n++;
			end
			@(negedge clk);
		end
		psel_i = 1'b0;
		penable_i = 1'b0;
		waits = done ? n : -1;
		if (!done) begin
			errors++;
			$display("%s: APB transfer to %h got no PREADY within %0d cycles", name, a, n);
		end
	endtask

	task automatic test_word_writes();
		addr_t a;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		read_line("word_writes", a + 20'h8, shadow[line_of(a)]);
		finish_test("word_writes", e0);
	endtask

	task automatic test_byte_writes();
		addr_t a;
		logic [31:0] rnd;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			core_write(1'b1, {a[19:4], rnd[3:0]}, {24'h0, rnd[15:8]});
		end
		read_line("byte_writes", a, shadow[line_of(a)]);
		finish_test("byte_writes", e0);
	endtask

	task automatic test_same_cycle();
		addr_t a;
		word_t d;
		line_t old_line;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		old_line = shadow[line_of(a)];
		d = $random(seed);
		drive_write(1'b0, a + 20'hc, d);
		read_line("same_cycle old", a, old_line);
		apply_write(1'b0, a + 20'hc, d);
		read_line("same_cycle new", a, shadow[line_of(a)]);
		finish_test("same_cycle", e0);
	endtask

	task automatic test_apb_core();
		addr_t a;
		word_t d;
		word_t rd;
		logic err;
		int waits;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		d = $random(seed);
		apb_xfer("apb_core write", 1'b1, a + 20'h4, d, rd, err, waits);
		apply_write(1'b0, a + 20'h4, d);
		check("apb_core write error", line_t'(0), line_t'(err));
		check("apb_core write waits", line_t'(1), line_t'(waits));
		read_line("apb_core core read", a, shadow[line_of(a)]);
		core_write(1'b0, a + 20'h8, $random(seed));
		apb_xfer("apb_core read", 1'b0, a + 20'h8, '0, rd, err, waits);
		check("apb_core read data", line_t'(word_of(shadow[line_of(a)], a + 20'h8)),
			line_t'(rd));
		check("apb_core read error", line_t'(0), line_t'(err));
		finish_test("apb_core", e0);
	endtask

	task automatic test_unaligned();
		addr_t a;
		word_t rd;
		logic err;
		int waits;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		apb_xfer("unaligned write", 1'b1, a + 20'h1, $random(seed), rd, err, waits);
		check("unaligned write error", line_t'(1), line_t'(err));
		check("unaligned write waits", line_t'(0), line_t'(waits));
		apb_xfer("unaligned read", 1'b0, a + 20'h6, '0, rd, err, waits);
		check("unaligned read error", line_t'(1), line_t'(err));
		read_line("unaligned unchanged", a, shadow[line_of(a)]);
		finish_test("unaligned", e0);
	endtask

	// the core holds the port for 20 cycles, so the grant comes in
	// the 20th access cycle and PREADY one cycle later
	task automatic test_apb_stall();
		addr_t a;
		word_t rd;
		logic err;
		int waits;
		int e0;
		e0 = errors;
		pick_line(a);
		fill_line(a);
		fork
			begin
				for (int i = 0; i < 20; i++) begin
					mem_read_i = 1'b1;
					mem_read_addr_i = a;
					#(CLK_PERIOD / 4);
					check("apb_stall pready low", line_t'(0), line_t'(pready_o));
					@(negedge clk);
				end
				mem_read_i = 1'b0;
			end
			apb_xfer("apb_stall", 1'b0, a + 20'h8, '0, rd, err, waits);
		join
		check("apb_stall waits", line_t'(20), line_t'(waits));
		check("apb_stall data", line_t'(word_of(shadow[line_of(a)], a + 20'h8)), line_t'(rd));
		check("apb_stall error", line_t'(0), line_t'(err));
		finish_test("apb_stall", e0);
	endtask

	initial begin
		seed = 32'hebfe;
		errors = 0;
		checks = 0;
		tests = 0;
		arst_n_i = 1'b0;
		mem_read_i = 1'b0;
		mem_read_addr_i = '0;
		mem_write_enable_i = 1'b0;
		mem_write_byte_i = 1'b0;
		mem_write_addr_i = '0;
		mem_write_data_i = '0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);
		test_word_writes();
		test_byte_writes();
		test_same_cycle();
		test_apb_core();
		test_unaligned();
		test_apb_stall();
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
logic/mem_pkg.sv
logic/line_bus_if.sv
logic/line_store.sv
logic/lane_merge.sv
logic/mem_ctrl.sv
logic/apb_host_port.sv
logic/line_mem_top.sv
testbench/tb_line_mem.sv

// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f list.f --top-module tb_line_mem

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 -f list.f \
		--top-module tb_line_mem -Mdir obj_dir -o tb_line_mem
	./obj_dir/tb_line_mem | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
